//--- bench/spiStimulus.txt
# columns: op index wdata expect abort, all but op in hex
# op: W write, R read, N read with valid clear, M write with valid clear
R 0 00000000 5A1B0001 0
R 3 00000000 00000000 0
W 1 DEADBEEF 00000000 0
R 1 00000000 DEADBEEF 0
W 5 12345678 00000000 0
W F A5A5C3C3 00000000 0
R 5 00000000 12345678 0
R F 00000000 A5A5C3C3 0
W 0 FFFFFFFF 00000000 0
R 0 00000000 5A1B0001 0
W 5 CAFEF00D 00000000 1
R 5 00000000 12345678 0
M 1 11112222 00000000 0
R 1 00000000 DEADBEEF 0
N 1 00000000 00000000 0
R 1 00000000 DEADBEEF 0
W 7 0F0F0F0F 00000000 0
R 7 00000000 0F0F0F0F 0
W 7 80000001 00000000 0
R 7 00000000 80000001 0
R 2 00000000 00000000 0

//--- sources.f
+incdir+hdl
hdl/spiBridgePkg.sv
hdl/spiSignal.sv
hdl/spiSignalMux.sv
hdl/csrBank.sv
hdl/spiBridgeTop.sv
bench/tbSpiBridge.sv

//--- run.sh
#!/bin/sh
# build and run the SPI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tbSpiBridge
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbSpiBridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- bench/tbSpiBridge.sv
/*
 * Testbench for spiBridgeTop, SPI mode 0, 4 iSCLK cycles per SCK phase.
 * Reads bench/spiStimulus.txt, so it must run from the project root.
 */
`timescale 1ns/1ps
`include "spiBridge_defines.svh"

module tbSpiBridge;

	// cycles allowed for any single wait
	localparam int waitLimit = 200;
	// bits sent before csN rises in an aborted frame
	localparam int abortBits = 40;
	localparam int frameBits = 2 * `SPI_BUS_WIDTH;

	logic iSCLK = 1'b0;
	logic arstN;
	logic sck;
	logic csN;
	logic mosi;
	logic miso;

	int mismatchCount;
	int failCount;
	logic timedOut;

	// reference register model, index 0 fixed at the ID value
	spiBridgePkg::busWordT modelRegs [0:`SPI_REG_COUNT-1];

	spiBridgeTop DUT
	(
		.iSCLK (iSCLK),
		.arstN (arstN),
		.sck   (sck),
		.csN   (csN),
		.mosi  (mosi),
		.miso  (miso)
	);

	// 100 ns period
	always #50 iSCLK = ~iSCLK;

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	task automatic checkReadWord(input spiBridgePkg::busWordT expected,
		input spiBridgePkg::busWordT observed, input string what);
		if (observed !== expected)
		begin
			mismatchCount++;
			$display("mismatch at %0d ns: %s expected %h got %h",
				$time, what, expected, observed);
		end
	endtask

	// miso must be low while deselected
	task automatic checkIdle(input logic observed);
		if (observed !== 1'b0)
		begin
			mismatchCount++;
			$display("mismatch at %0d ns: miso is %b while csN is high", $time, observed);
		end
	endtask

	// ----------------------------------------------------------
	// SPI master side
	// ----------------------------------------------------------
	// flags and index packed into an address word
	function automatic spiBridgePkg::busWordT makeAdrs(input logic valid,
		input logic write, input spiBridgePkg::regIndexT index);
		spiBridgePkg::busWordT word;
		word = '0;
		word[`SPI_ADRS_VALID_BIT] = valid;
		word[`SPI_ADRS_WRITE_BIT] = write;
		word[$bits(spiBridgePkg::regIndexT)-1:0] = index;
		return word;
	endfunction

	// one SCK period, low phase then high phase
	// miso sampled just before the rising edge
	task automatic shiftBit(input logic txBit, output logic rxBit);
		@(posedge iSCLK);
		sck <= 1'b0;
		mosi <= txBit;
		repeat (3) @(posedge iSCLK);
		@(negedge iSCLK);
		rxBit = miso;
		@(posedge iSCLK);
		sck <= 1'b1;
		repeat (3) @(posedge iSCLK);
	endtask

	// bounded wait on the serial stage FSM
	task automatic waitForState(input spiBridgePkg::spiStateT target, input string what);
		int cycles;
		cycles = 0;
		while (DUT.uSpiSignal.state != target && cycles < waitLimit)
		begin
			@(posedge iSCLK);
			cycles++;
		end
		if (DUT.uSpiSignal.state != target)
		begin
			failCount++;
			timedOut = 1'b1;
			$display("timeout at %0d ns: serial stage did not reach %s", $time, what);
		end
	endtask

	// full or aborted frame, returns the data word seen on miso
	task automatic runFrame(input spiBridgePkg::busWordT adrsWord,
		input spiBridgePkg::busWordT dataWord, input logic abort,
		output spiBridgePkg::busWordT captured);
		logic [frameBits-1:0] txFrame;
		int bitCount;
		logic rxBit;
		txFrame = {adrsWord, dataWord};
		bitCount = abort ? abortBits : frameBits;
		captured = '0;
		@(posedge iSCLK);
		csN <= 1'b0;
		// let the chip select edge through the synchronizer
		repeat (4) @(posedge iSCLK);
		for (int i = frameBits - 1; i >= frameBits - bitCount; i--)
		begin
			shiftBit(txFrame[i], rxBit);
			// data word, MSB first
			if (i < `SPI_BUS_WIDTH)
				captured = {captured[`SPI_BUS_WIDTH-2:0], rxBit};
		end
		if (!abort)
			waitForState(spiBridgePkg::DONE, "DONE");
		// SCK back to idle low, then deselect
		@(posedge iSCLK);
		sck <= 1'b0;
		mosi <= 1'b0;
		repeat (4) @(posedge iSCLK);
		csN <= 1'b1;
		// last shifted bit still held inside, only csN gates it
		@(negedge iSCLK);
		checkIdle(miso);
		waitForState(spiBridgePkg::IDLE, "IDLE");
		@(negedge iSCLK);
		checkIdle(miso);
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial
	begin
		int fd;
		int code;
		logic [7:0] opChar;
		spiBridgePkg::regIndexT index;
		spiBridgePkg::busWordT wData;
		spiBridgePkg::busWordT fileExpect;
		spiBridgePkg::busWordT modelExpect;
		spiBridgePkg::busWordT captured;
		logic abortFlag;
		logic validFlag;
		logic writeFlag;
		logic endOfFile;
		logic [8*128-1:0] restOfLine;
		string what;

		mismatchCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		endOfFile = 1'b0;
		arstN = 1'b0;
		sck = 1'b0;
		csN = 1'b1;
		mosi = 1'b0;
		for (int i = 0; i < `SPI_REG_COUNT; i++)
			modelRegs[i] = '0;
		modelRegs[0] = `SPI_ID_VALUE;

		repeat (8) @(posedge iSCLK);
		arstN <= 1'b1;
		repeat (2) @(posedge iSCLK);
		@(negedge iSCLK);
		checkIdle(miso);

		fd = $fopen("bench/spiStimulus.txt", "r");
		if (fd == 0)
		begin
			failCount++;
			$display("could not open bench/spiStimulus.txt");
			endOfFile = 1'b1;
		end

		while (!endOfFile && !timedOut)
		begin
			code = $fscanf(fd, " %c", opChar);
			if (code != 1)
				endOfFile = 1'b1;
			else if (opChar == "#")
				// column notes, skip the rest of the line
				code = $fgets(restOfLine, fd);
			else
			begin
				code = $fscanf(fd, "%h %h %h %h", index, wData, fileExpect, abortFlag);
				if (code != 4)
				begin
					failCount++;
					$display("stimulus line for operation %c is incomplete", opChar);
					endOfFile = 1'b1;
				end
				else if (opChar != "W" && opChar != "R" && opChar != "N" && opChar != "M")
				begin
					failCount++;
					$display("unknown operation %c in stimulus file", opChar);
				end
				else
				begin
					// N and M carry a clear valid flag
					validFlag = (opChar == "W" || opChar == "R");
					writeFlag = (opChar == "W" || opChar == "M");
					runFrame(makeAdrs(validFlag, writeFlag, index), wData, abortFlag, captured);
					// only a valid read returns data
					modelExpect = (opChar == "R") ? modelRegs[index] : '0;
					if (!abortFlag && !timedOut)
					begin
						what = $sformatf("%c frame to index %0d", opChar, index);
						checkReadWord(modelExpect, captured, {what, " vs model"});
						checkReadWord(fileExpect, captured, {what, " vs file"});
					end
					// completed writes only, index 0 stays fixed
					if (opChar == "W" && !abortFlag && !timedOut && index != '0)
						modelRegs[index] = wData;
				end
			end
		end

		if (fd != 0)
			$fclose(fd);
		$display("error count: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- hdl/spiBridgeTop.sv
/*
 * SPI slave to register bus bridge, mode 0, MSB first.
 * SCK at most iSCLK / 8; miso is low while csN is high.
 */
`timescale 1ns/1ps

module spiBridgeTop
(
	input  logic iSCLK,
	input  logic arstN,
	input  logic sck,
	input  logic csN,
	input  logic mosi,
	output logic miso
);

	// serial stage to bus register stage
	spiBridgePkg::busWordT spiRd;
	spiBridgePkg::busWordT spiAdrs;
	logic spiREd;
	spiBridgePkg::busWordT mUsiRd;
	// bus register stage to register bank
	spiBridgePkg::busWordT mUsiWd;
	spiBridgePkg::busWordT mUsiAdrs;
	spiBridgePkg::busWordT mUsiRdIn;

	// ----------------------------------------------------------
	// pin level serial stage
	// ----------------------------------------------------------
	spiSignal uSpiSignal
	(
		.iSCLK   (iSCLK),
		.arstN   (arstN),
		.sck     (sck),
		.csN     (csN),
		.mosi    (mosi),
		.miso    (miso),
		.mUsiRd  (mUsiRd),
		.spiRd   (spiRd),
		.spiAdrs (spiAdrs),
		.spiREd  (spiREd)
	);

	// bus register stage
	spiSignalMux uSpiSignalMux
	(
		.iSCLK    (iSCLK),
		.arstN    (arstN),
		.spiRd    (spiRd),
		.spiAdrs  (spiAdrs),
		.spiREd   (spiREd),
		.mUsiRdIn (mUsiRdIn),
		.mUsiRd   (mUsiRd),
		.mUsiWd   (mUsiWd),
		.mUsiAdrs (mUsiAdrs)
	);

	// register bank
	csrBank uCsrBank
	(
		.iSCLK    (iSCLK),
		.arstN    (arstN),
		.mUsiWd   (mUsiWd),
		.mUsiAdrs (mUsiAdrs),
		.mUsiRdIn (mUsiRdIn)
	);

endmodule

//--- hdl/csrBank.sv
/*
 * Sixteen 32-bit control registers on the bridge bus.
 * Index 0 is read-only and returns SPI_ID_VALUE; writes to it are dropped.
 * Access happens only while the valid flag of mUsiAdrs is set.
 */
`timescale 1ns/1ps
`include "spiBridge_defines.svh"

module csrBank
(
	input  logic                  iSCLK,
	input  logic                  arstN,
	input  spiBridgePkg::busWordT mUsiWd,
	input  spiBridgePkg::busWordT mUsiAdrs,
	output spiBridgePkg::busWordT mUsiRdIn
);

	// ----------------------------------------------------------
	// address decode
	// ----------------------------------------------------------
	spiBridgePkg::regIndexT regIndex;
	logic adrsValid;
	logic wrEn;

	assign regIndex = mUsiAdrs[$bits(spiBridgePkg::regIndexT)-1:0];
	assign adrsValid = mUsiAdrs[`SPI_ADRS_VALID_BIT];
	// index 0 never takes a write
	assign wrEn = adrsValid && mUsiAdrs[`SPI_ADRS_WRITE_BIT] && (regIndex != '0);

	// ----------------------------------------------------------
	// register storage
	// ----------------------------------------------------------
	// writable registers 1 to 15
	spiBridgePkg::busWordT regFile [1:`SPI_REG_COUNT-1];

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 1; i < `SPI_REG_COUNT; i++)
				regFile[i] <= '0;
		end
		else if (wrEn)
		begin
			// lands at the end of the valid cycle
			regFile[regIndex] <= mUsiWd;
		end
	end

	// ----------------------------------------------------------
	// read back
	// ----------------------------------------------------------
	// combinational from the address
	always_comb
	begin
		mUsiRdIn = '0;
		if (adrsValid)
		begin
			if (regIndex == '0)
				mUsiRdIn = `SPI_ID_VALUE;
			else
				mUsiRdIn = regFile[regIndex];
		end
	end

endmodule

//--- hdl/spiSignalMux.sv
/*
 * Register stage between the serial stage and the register bank.
 * Address is nonzero only in the cycle after a strobe.
 * Read data passes back unregistered.
 */
`timescale 1ns/1ps

module spiSignalMux
(
	input  logic                  iSCLK,
	input  logic                  arstN,
	input  spiBridgePkg::busWordT spiRd,
	input  spiBridgePkg::busWordT spiAdrs,
	input  logic                  spiREd,
	input  spiBridgePkg::busWordT mUsiRdIn,
	output spiBridgePkg::busWordT mUsiRd,
	output spiBridgePkg::busWordT mUsiWd,
	output spiBridgePkg::busWordT mUsiAdrs
);

	// ----------------------------------------------------------
	// bus side registers
	// ----------------------------------------------------------
	// write data follows the serial stage every cycle
	always_ff @(posedge iSCLK)
	begin
		mUsiWd <= spiRd;
	end

	// address only on the strobe
	// valid flag inside marks the single access cycle
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			mUsiAdrs <= '0;
		else if (spiREd)
			mUsiAdrs <= spiAdrs;
		else
			mUsiAdrs <= '0;
	end

	// bank read data straight back
	assign mUsiRd = mUsiRdIn;

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// no bus access without a preceding strobe
	adrsIdleZero: assert property (@(posedge iSCLK) disable iff (!arstN)
		!spiREd |=> mUsiAdrs == '0);

endmodule

//--- hdl/spiSignal.sv
/*
 * SPI mode 0 slave, MSB first, 64-bit frames (address word then data word).
 * Pins are oversampled by iSCLK, so SCK must be <= iSCLK / 8.
 * Raising csN mid-frame drops the frame without a bus strobe.
 */
`timescale 1ns/1ps
`include "spiBridge_defines.svh"

module spiSignal
(
	input  logic                  iSCLK,
	input  logic                  arstN,
	input  logic                  sck,
	input  logic                  csN,
	input  logic                  mosi,
	output logic                  miso,
	input  spiBridgePkg::busWordT mUsiRd,
	output spiBridgePkg::busWordT spiRd,
	output spiBridgePkg::busWordT spiAdrs,
	output logic                  spiREd
);
	localparam int unsigned cntWidth = $clog2(`SPI_BUS_WIDTH);
	localparam logic [cntWidth-1:0] lastCnt = cntWidth'(`SPI_BUS_WIDTH - 1);

	// ----------------------------------------------------------
	// pin synchronizers and edge detect
	// ----------------------------------------------------------
	logic [1:0] sckSync;
	logic [1:0] csSync;
	logic [1:0] mosiSync;
	logic sckDly;
	logic csDly;
	logic sckRise;
	logic sckFall;
	logic csRise;
	logic csFall;

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			sckSync <= '0;
			sckDly <= 1'b0;
			// chip select idles high
			csSync <= '1;
			csDly <= 1'b1;
			mosiSync <= '0;
		end
		else
		begin
			sckSync <= {sckSync[0], sck};
			sckDly <= sckSync[1];
			csSync <= {csSync[0], csN};
			csDly <= csSync[1];
			mosiSync <= {mosiSync[0], mosi};
		end
	end

	// edges seen two flops after the pins
	assign sckRise = sckSync[1] & ~sckDly;
	assign sckFall = ~sckSync[1] & sckDly;
	assign csRise = csSync[1] & ~csDly;
	assign csFall = ~csSync[1] & csDly;

	// ----------------------------------------------------------
	// frame decode
	// ----------------------------------------------------------
	spiBridgePkg::spiStateT state;
	logic [cntWidth-1:0] bitCnt;
	spiBridgePkg::busWordT adrsShift;
	spiBridgePkg::busWordT dataShift;
	spiBridgePkg::busWordT misoShift;
	spiBridgePkg::busWordT adrsWord;
	spiBridgePkg::busWordT dataWord;
	logic misoBit;
	logic rdLoad;
	logic lastBit;
	logic isRead;
	logic writeEnd;

	assign lastBit = (bitCnt == lastCnt);
	// full words including the bit arriving on this rising edge
	assign adrsWord = {adrsShift[`SPI_BUS_WIDTH-2:0], mosiSync[1]};
	assign dataWord = {dataShift[`SPI_BUS_WIDTH-2:0], mosiSync[1]};
	// valid and not write
	assign isRead = adrsWord[`SPI_ADRS_VALID_BIT] & ~adrsWord[`SPI_ADRS_WRITE_BIT];
	// last data bit of a valid write frame
	assign writeEnd = (state == spiBridgePkg::DATA) && sckRise && lastBit
		&& adrsShift[`SPI_ADRS_VALID_BIT] && adrsShift[`SPI_ADRS_WRITE_BIT];

	// shift registers and bus data, no reset
	always_ff @(posedge iSCLK)
	begin
		if (sckRise && state == spiBridgePkg::ADRS)
			adrsShift <= adrsWord;
		if (sckRise && state == spiBridgePkg::DATA)
			dataShift <= dataWord;
		// read strobe carries zero data
		if (state == spiBridgePkg::RDWAIT)
			spiRd <= '0;
		else if (writeEnd)
			spiRd <= dataWord;
	end

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= spiBridgePkg::IDLE;
			bitCnt <= '0;
			spiREd <= 1'b0;
			rdLoad <= 1'b0;
			misoShift <= '0;
			misoBit <= 1'b0;
		end
		else
		begin
			// strobe defaults low, one-cycle pulse
			spiREd <= 1'b0;
			// read data is back from the bank one cycle after the strobe
			rdLoad <= spiREd && (state == spiBridgePkg::DATA);
			if (csSync[1])
			begin
				// deselect or abort
				state <= spiBridgePkg::IDLE;
				bitCnt <= '0;
				misoShift <= '0;
				misoBit <= 1'b0;
			end
			else
			begin
				case (state)
					spiBridgePkg::IDLE:
					begin
						bitCnt <= '0;
						if (csFall)
							state <= spiBridgePkg::ADRS;
					end
					spiBridgePkg::ADRS:
					begin
						if (sckRise)
						begin
							bitCnt <= bitCnt + 1'b1;
							if (lastBit)
								state <= isRead ? spiBridgePkg::RDWAIT : spiBridgePkg::DATA;
						end
					end
					spiBridgePkg::RDWAIT:
					begin
						spiREd <= 1'b1;
						state <= spiBridgePkg::DATA;
					end
					spiBridgePkg::DATA:
					begin
						// load wins, next SCK fall is several cycles away
						if (rdLoad)
							misoShift <= mUsiRd;
						else if (sckFall)
						begin
							misoBit <= misoShift[`SPI_BUS_WIDTH-1];
							misoShift <= {misoShift[`SPI_BUS_WIDTH-2:0], 1'b0};
						end
						if (sckRise)
						begin
							bitCnt <= bitCnt + 1'b1;
							if (lastBit)
							begin
								state <= spiBridgePkg::DONE;
								spiREd <= writeEnd;
							end
						end
					end
					default:
					begin
						// DONE, hold until csN rises
						bitCnt <= '0;
					end
				endcase
			end
		end
	end

	assign spiAdrs = adrsShift;
	// held low while deselected
	assign miso = misoBit & ~csN;

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// one strobe per access, never back to back
	strobePulse: assert property (@(posedge iSCLK) disable iff (!arstN)
		spiREd |=> !spiREd);

	// deselect always ends the frame
	csReturnsIdle: assert property (@(posedge iSCLK) disable iff (!arstN)
		csRise |=> state == spiBridgePkg::IDLE);

	// SCK high phase long enough for the read load
	sckOversample: assert property (@(posedge iSCLK) disable iff (!arstN)
		sckRise |=> !sckFall [*(`SPI_OVERSAMPLE_MIN / 2 - 1)]);

endmodule

//--- hdl/spiBridgePkg.sv
/*
 * Types shared across the SPI bridge.
 * Widths follow spiBridge_defines.svh.
 */
`include "spiBridge_defines.svh"

package spiBridgePkg;

	// ----------------------------------------------------------
	// bus types
	// ----------------------------------------------------------
	// one word on the register bus, data or address
	typedef logic [`SPI_BUS_WIDTH-1:0] busWordT;

	// register index, low bits of the address word
	typedef logic [$clog2(`SPI_REG_COUNT)-1:0] regIndexT;

	// ----------------------------------------------------------
	// serial stage FSM
	// ----------------------------------------------------------
	typedef enum logic [2:0]
	{
		// waiting for chip select to fall
		IDLE,
		// shifting in the address word
		ADRS,
		// one cycle to raise the read strobe
		RDWAIT,
		// shifting the data word in and out
		DATA,
		// frame complete, waiting for chip select to rise
		DONE
	} spiStateT;

endpackage

//--- hdl/spiBridge_defines.svh
/*
 * SPI bridge constants shared by the package and all RTL.
 * SCK must stay at or below iSCLK / SPI_OVERSAMPLE_MIN.
 * Register 0 is read-only and always returns SPI_ID_VALUE.
 */
`ifndef SPI_BRIDGE_DEFINES_SVH
`define SPI_BRIDGE_DEFINES_SVH

// ----------------------------------------------------------
// bus geometry
// ----------------------------------------------------------
`define SPI_BUS_WIDTH 32
`define SPI_REG_COUNT 16

// flag positions inside the address word
`define SPI_ADRS_VALID_BIT 31
`define SPI_ADRS_WRITE_BIT 30

// ----------------------------------------------------------
// timing and identity
// ----------------------------------------------------------
// minimum iSCLK cycles per SCK period
`define SPI_OVERSAMPLE_MIN 8
// fixed contents of register 0
`define SPI_ID_VALUE 32'h5A1B_0001

`endif
